//--- Bender.yml
package:
  name: execute_stage

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - rtl/exec_data_pkg.sv
      - rtl/exec_ctrl_pkg.sv
      - rtl/cla_adder.sv
      - rtl/exec_alu.sv
      - rtl/branch_unit.sv
      - rtl/execute_stage.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/execute_stage_props.sv
      - verification/tb_execute_stage.sv

//--- filelist.f
+incdir+include
rtl/exec_data_pkg.sv
rtl/exec_ctrl_pkg.sv
rtl/cla_adder.sv
rtl/exec_alu.sv
rtl/branch_unit.sv
rtl/execute_stage.sv
verification/execute_stage_props.sv
verification/tb_execute_stage.sv

//--- include/exec_cfg.svh
/* Execute stage configuration
   Datapath width, shift amount width and adder lookahead group size */

`ifndef EXEC_CFG_SVH
`define EXEC_CFG_SVH

// Datapath width in bits
`define EXEC_WIDTH     16

// Shift and rotate amount, low bits of the second operand
`define EXEC_SHAMT_W   4

// Bits per carry-lookahead group
`define EXEC_CLA_GROUP 4

`endif

//--- rtl/branch_unit.sv
/* Branch unit
   Condition check, PC-relative target and redirect decision */

`timescale 1ns/10ps
`default_nettype none

module branch_unit (
   input  exec_data_pkg::word_t    pc_inc,
   input  exec_data_pkg::word_t    sext_imm,
   input  exec_data_pkg::word_t    alu_result,
   input  logic                    alu_zero,
   input  logic                    op1_neg,
   input  exec_ctrl_pkg::br_cond_t br_cond,
   input  logic                    br_instr,
   input  logic                    jmp_instr,
   input  logic                    jmp_reg_instr,
   output logic                    take_new_pc,
   output exec_data_pkg::word_t    new_pc
);

   import exec_data_pkg::*;
   import exec_ctrl_pkg::*;

   word_t rel_target;
   logic  cond_met;

   // Relative target, pc_inc plus immediate
   cla_adder i_pc_adder (
      .a    (pc_inc),
      .b    (sext_imm),
      .cin  (1'b0),
      .sum  (rel_target),
      .cout ()
   );

   // Zero test uses the ALU pass of the first operand
   always_comb begin
      case (br_cond)
         BR_EQZ:  cond_met = alu_zero;
         BR_NEZ:  cond_met = ~alu_zero;
         BR_LTZ:  cond_met = op1_neg;
         BR_GEZ:  cond_met = ~op1_neg;
         default: cond_met = 1'b0;
      endcase
   end

   assign take_new_pc = jmp_instr | jmp_reg_instr | (br_instr & cond_met);

   // Register jumps take the ALU sum of register and immediate
   assign new_pc = jmp_reg_instr ? alu_result : rel_target;

endmodule

`default_nettype wire

//--- rtl/cla_adder.sv
/* Carry-lookahead adder
   Bit generate/propagate folded into lookahead groups, carries chained per group */

`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module cla_adder (
   input  exec_data_pkg::word_t a,
   input  exec_data_pkg::word_t b,
   input  logic                 cin,
   output exec_data_pkg::word_t sum,
   output logic                 cout
);

   import exec_data_pkg::*;

   localparam int GRP  = `EXEC_CLA_GROUP;
   localparam int NGRP = `EXEC_WIDTH / GRP;

   word_t           gen;
   word_t           prop;
   word_t           carry;
   logic [NGRP-1:0] grp_gen;
   logic [NGRP-1:0] grp_prop;
   logic [NGRP:0]   grp_carry;

   assign gen  = a & b;
   assign prop = a ^ b;

   // Group generate and propagate
   always_comb begin
      for (int k = 0; k < NGRP; k++) begin
         grp_gen[k]  = 1'b0;
         grp_prop[k] = 1'b1;
         for (int i = 0; i < GRP; i++) begin
            grp_gen[k]  = gen[k*GRP+i] | (prop[k*GRP+i] & grp_gen[k]);
            grp_prop[k] = grp_prop[k] & prop[k*GRP+i];
         end
      end
   end

   // Carry into each group from the group terms only
   always_comb begin
      grp_carry[0] = cin;
      for (int k = 0; k < NGRP; k++) begin
         grp_carry[k+1] = grp_gen[k] | (grp_prop[k] & grp_carry[k]);
      end
   end

   // Carries inside a group start from the group carry
   always_comb begin
      for (int k = 0; k < NGRP; k++) begin
         carry[k*GRP] = grp_carry[k];
         for (int i = 1; i < GRP; i++) begin
            carry[k*GRP+i] = gen[k*GRP+i-1] | (prop[k*GRP+i-1] & carry[k*GRP+i-1]);
         end
      end
   end

   assign sum  = prop ^ carry;
   assign cout = grp_carry[NGRP];

endmodule

`default_nettype wire

//--- rtl/exec_alu.sv
/* Execute stage ALU
   Optional operand inversion, shifts, rotates, add and logic ops with compare flags */

`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module exec_alu (
   input  exec_data_pkg::word_t   in_a,
   input  exec_data_pkg::word_t   in_b,
   input  logic                   cin,
   input  exec_ctrl_pkg::alu_op_t op,
   input  logic                   inv_a,
   input  logic                   inv_b,
   input  logic                   sign,
   output exec_data_pkg::word_t   result,
   output logic                   zero,
   output logic                   ofl,
   output logic                   lt,
   output logic                   lte
);

   import exec_data_pkg::*;
   import exec_ctrl_pkg::*;

   localparam int MSB = `EXEC_WIDTH - 1;

   word_t                     op_a;
   word_t                     op_b;
   shamt_t                    shamt;
   word_t                     add_sum;
   logic                      add_cout;
   logic                      signed_ofl;
   logic [2*`EXEC_WIDTH-1:0]  rot_left;
   logic [2*`EXEC_WIDTH-1:0]  rot_right;

   assign op_a  = inv_a ? ~in_a : in_a;
   assign op_b  = inv_b ? ~in_b : in_b;
   assign shamt = op_b[`EXEC_SHAMT_W-1:0];

   cla_adder i_cla_adder (
      .a    (op_a),
      .b    (op_b),
      .cin  (cin),
      .sum  (add_sum),
      .cout (add_cout)
   );

   // Rotates shift a doubled copy, the wrapped bits land in the kept half
   assign rot_left  = {op_a, op_a} << shamt;
   assign rot_right = {op_a, op_a} >> shamt;

   always_comb begin
      case (op)
         ALU_ROL: result = rot_left[2*`EXEC_WIDTH-1:`EXEC_WIDTH];
         ALU_SLL: result = op_a << shamt;
         ALU_ROR: result = rot_right[MSB:0];
         ALU_SRL: result = op_a >> shamt;
         ALU_ADD: result = add_sum;
         ALU_OR:  result = op_a | op_b;
         ALU_XOR: result = op_a ^ op_b;
         ALU_AND: result = op_a & op_b;
         default: result = '0;
      endcase
   end

   assign zero = (result == '0);

   // Operands agree in sign but the sum does not
   assign signed_ofl = (op_a[MSB] == op_b[MSB]) && (add_sum[MSB] != op_a[MSB]);

   assign ofl = (op == ALU_ADD) ? (sign ? signed_ofl : add_cout) : 1'b0;

   // Compare after inversion
   assign lt  = sign ? ($signed(op_a) <  $signed(op_b)) : (op_a <  op_b);
   assign lte = sign ? ($signed(op_a) <= $signed(op_b)) : (op_a <= op_b);

endmodule

`default_nettype wire

//--- rtl/exec_ctrl_pkg.sv
/* Execute stage control encodings
   ALU operation, branch condition and set flag select */

`default_nettype none

package exec_ctrl_pkg;

   // ALU operation
   typedef logic [2:0] alu_op_t;

   localparam alu_op_t ALU_ROL = 3'd0;
   localparam alu_op_t ALU_SLL = 3'd1;
   localparam alu_op_t ALU_ROR = 3'd2;
   localparam alu_op_t ALU_SRL = 3'd3;
   localparam alu_op_t ALU_ADD = 3'd4;
   localparam alu_op_t ALU_OR  = 3'd5;
   localparam alu_op_t ALU_XOR = 3'd6;
   localparam alu_op_t ALU_AND = 3'd7;

   // Branch condition, tested on the first operand
   typedef logic [1:0] br_cond_t;

   localparam br_cond_t BR_EQZ = 2'd0;
   localparam br_cond_t BR_NEZ = 2'd1;
   localparam br_cond_t BR_LTZ = 2'd2;
   localparam br_cond_t BR_GEZ = 2'd3;

   // Flag written by set-type instructions
   typedef logic [1:0] set_sel_t;

   localparam set_sel_t SET_OFL  = 2'd0;
   localparam set_sel_t SET_ZERO = 2'd1;
   localparam set_sel_t SET_LT   = 2'd2;
   localparam set_sel_t SET_LTE  = 2'd3;

endpackage

`default_nettype wire

//--- rtl/exec_data_pkg.sv
/* Execute stage data types
   Words, byte halves and shift amounts */

`default_nettype none

`include "exec_cfg.svh"

package exec_data_pkg;

   // Operand, result or PC value
   typedef logic [`EXEC_WIDTH-1:0] word_t;

   // Half word used by shift-and-load-immediate
   typedef logic [`EXEC_WIDTH/2-1:0] byte_t;

   // Shift or rotate amount
   typedef logic [`EXEC_SHAMT_W-1:0] shamt_t;

endpackage

`default_nettype wire

//--- rtl/execute_stage.sv
/* Execute stage of the 16-bit pipeline
   Forwarding, ALU, set flag, load-immediate and branch results into the EX/MEM register */

`timescale 1ns/10ps
`default_nettype none

`include "exec_cfg.svh"

module execute_stage (
   input  logic                    clk,
   input  logic                    rst,
   input  logic                    stall,
   input  logic                    in_valid,
   input  exec_data_pkg::word_t    oprnd_1,
   input  exec_data_pkg::word_t    oprnd_2,
   input  exec_data_pkg::word_t    sext_imm,
   input  exec_data_pkg::word_t    pc_inc,
   input  exec_ctrl_pkg::alu_op_t  alu_op,
   input  logic                    alu_inv_a,
   input  logic                    alu_inv_b,
   input  logic                    alu_cin,
   input  logic                    alu_sign,
   input  exec_ctrl_pkg::set_sel_t set_sel,
   input  exec_ctrl_pkg::br_cond_t br_cond,
   input  logic                    br_instr,
   input  logic                    jmp_instr,
   input  logic                    jmp_reg_instr,
   input  logic                    ex_fwd_rs,
   input  logic                    ex_fwd_rt,
   input  logic                    mem_fwd_rs,
   input  logic                    mem_fwd_rt,
   input  exec_data_pkg::word_t    ex_rs_val,
   input  exec_data_pkg::word_t    ex_rt_val,
   input  exec_data_pkg::word_t    mem_rs_val,
   input  exec_data_pkg::word_t    mem_rt_val,
   output logic                    out_valid,
   output exec_data_pkg::word_t    alu_out,
   output logic                    ofl,
   output logic                    zero,
   output logic                    ltz,
   output logic                    lteq,
   output logic                    set,
   output logic                    take_new_pc,
   output exec_data_pkg::word_t    new_pc,
   output exec_data_pkg::word_t    lbi,
   output exec_data_pkg::word_t    slbi
);

   import exec_data_pkg::*;
   import exec_ctrl_pkg::*;

   word_t fwd_a;
   word_t fwd_b;
   word_t alu_res;
   logic  alu_zero;
   logic  alu_ofl;
   logic  alu_lt;
   logic  alu_lte;
   logic  set_next;
   logic  br_take;
   word_t br_target;
   byte_t slbi_hi;
   byte_t slbi_lo;

   // Youngest producer wins: EX result, then MEM result, then register file
   assign fwd_a = ex_fwd_rs  ? ex_rs_val  :
                  mem_fwd_rs ? mem_rs_val : oprnd_1;
   assign fwd_b = ex_fwd_rt  ? ex_rt_val  :
                  mem_fwd_rt ? mem_rt_val : oprnd_2;

   exec_alu i_exec_alu (
      .in_a   (fwd_a),
      .in_b   (fwd_b),
      .cin    (alu_cin),
      .op     (alu_op),
      .inv_a  (alu_inv_a),
      .inv_b  (alu_inv_b),
      .sign   (alu_sign),
      .result (alu_res),
      .zero   (alu_zero),
      .ofl    (alu_ofl),
      .lt     (alu_lt),
      .lte    (alu_lte)
   );

   branch_unit i_branch_unit (
      .pc_inc        (pc_inc),
      .sext_imm      (sext_imm),
      .alu_result    (alu_res),
      .alu_zero      (alu_zero),
      .op1_neg       (fwd_a[`EXEC_WIDTH-1]),
      .br_cond       (br_cond),
      .br_instr      (br_instr),
      .jmp_instr     (jmp_instr),
      .jmp_reg_instr (jmp_reg_instr),
      .take_new_pc   (br_take),
      .new_pc        (br_target)
   );

   // Set-type result flag
   always_comb begin
      case (set_sel)
         SET_OFL:  set_next = alu_ofl;
         SET_ZERO: set_next = alu_zero;
         SET_LT:   set_next = alu_lt;
         SET_LTE:  set_next = alu_lte;
         default:  set_next = 1'b0;
      endcase
   end

   // Low bytes of first operand and immediate
   assign slbi_hi = byte_t'(fwd_a);
   assign slbi_lo = byte_t'(sext_imm);

   // EX/MEM register, held while memory stalls
   always_ff @(posedge clk) begin
      if (rst) begin
         out_valid   <= 1'b0;
         alu_out     <= '0;
         ofl         <= 1'b0;
         zero        <= 1'b0;
         ltz         <= 1'b0;
         lteq        <= 1'b0;
         set         <= 1'b0;
         take_new_pc <= 1'b0;
         new_pc      <= '0;
         lbi         <= '0;
         slbi        <= '0;
      end else if (!stall) begin
         out_valid   <= in_valid;
         alu_out     <= alu_res;
         ofl         <= alu_ofl;
         zero        <= alu_zero;
         ltz         <= alu_lt;
         lteq        <= alu_lte;
         set         <= set_next;
         take_new_pc <= br_take;
         new_pc      <= br_target;
         lbi         <= sext_imm;
         slbi        <= {slbi_hi, slbi_lo};
      end
   end

endmodule

`default_nettype wire

//--- verification/exec_vectors.txt
# stall valid alu_op inv_a.inv_b.cin.sign set_sel br_cond br.jmp.jmpr ex_rs.ex_rt.mem_rs.mem_rt
# oprnd_1 oprnd_2 sext_imm pc_inc ex_rs_val ex_rt_val mem_rs_val mem_rt_val, then expected
# out_valid.ofl.zero.ltz.lteq.set.take_new_pc alu_out new_pc lbi slbi (held values on stalls)
0 1 0 0000 1 0 000 0000 8001 0004 0012 0100 0000 0000 0000 0000 1000000 0018 0112 0012 0112
0 1 1 0000 2 0 000 0000 00f3 0004 0005 0200 0000 0000 0000 0000 1000000 0f30 0205 0005 f305
0 1 2 0000 3 0 000 0000 0001 0001 ffff 0010 0000 0000 0000 0000 1000110 8000 000f ffff 01ff
0 1 3 0001 2 0 000 0000 8000 000f 0000 0300 0000 0000 0000 0000 1001110 0001 0300 0000 0000
0 1 3 0100 1 0 000 0000 ff00 fff7 0001 0000 0000 0000 0000 0000 1000000 00ff 0001 0001 0001
0 1 4 0000 0 0 000 0000 ffff 0001 0002 0010 0000 0000 0000 0000 1110010 0000 0012 0002 ff02
0 1 4 0001 0 0 000 0000 7fff 0001 0000 0000 0000 0000 0000 0000 1100010 8000 0000 0000 ff00
0 1 4 0111 2 0 000 0000 0005 0007 0003 0020 0000 0000 0000 0000 1000000 fffe 0023 0003 0503
0 1 4 0001 3 0 000 0000 fff0 0010 0004 0040 0000 0000 0000 0000 1011110 0000 0044 0004 f004
0 1 5 1000 2 0 000 0000 ff0f 0f00 0006 0000 0000 0000 0000 0000 1001110 0ff0 0006 0006 0f06
0 1 6 0000 1 0 000 0000 aaaa aaaa 0007 0000 0000 0000 0000 0000 1010110 0000 0007 0007 aa07
0 1 7 1100 0 0 000 0000 f0f0 ff00 0008 0000 0000 0000 0000 0000 1000000 000f 0008 0008 f008
0 1 4 0000 2 0 000 1011 1111 2222 0001 1000 0100 0200 0300 0400 1001110 0500 1001 0001 0001
0 1 4 0000 3 0 000 0111 1111 2222 0002 1000 0100 0200 0300 0400 1000000 0500 1002 0002 0002
0 1 4 0000 2 0 000 0000 1111 2222 0003 1000 0100 0200 0300 0400 1001110 3333 1003 0003 1103
0 0 0 0000 0 0 000 0000 0000 0000 0000 0000 0000 0000 0000 0000 0010100 0000 0000 0000 0000
0 1 5 0000 1 0 100 0000 0000 0000 0010 0200 0000 0000 0000 0000 1010111 0000 0210 0010 0010
0 1 5 0000 1 0 100 0000 0004 0000 0010 0200 0000 0000 0000 0000 1000000 0004 0210 0010 0410
0 1 5 0000 1 1 100 0000 0004 0000 fff0 0200 0000 0000 0000 0000 1000001 0004 01f0 fff0 04f0
0 1 5 0000 1 1 100 0000 0000 0000 fff0 0200 0000 0000 0000 0000 1010110 0000 01f0 fff0 00f0
0 1 5 0000 1 2 100 0000 8000 0000 0020 0300 0000 0000 0000 0000 1000001 8000 0320 0020 0020
0 1 5 0000 1 2 100 0000 7fff 0000 0020 0300 0000 0000 0000 0000 1000000 7fff 0320 0020 ff20
0 1 5 0000 1 3 100 0000 0001 0000 0020 0300 0000 0000 0000 0000 1000001 0001 0320 0020 0120
0 1 5 0000 1 3 100 0000 ffff 0000 0020 0300 0000 0000 0000 0000 1000000 ffff 0320 0020 ff20
1 1 4 0000 0 0 010 0000 1234 1111 0055 0400 0000 0000 0000 0000 1000000 ffff 0320 0020 ff20
1 0 0 0000 0 0 000 0000 0000 0000 0000 0000 0000 0000 0000 0000 1000000 ffff 0320 0020 ff20
0 1 5 0000 1 0 010 0000 0000 0000 0040 0100 0000 0000 0000 0000 1010111 0000 0140 0040 0040
0 1 4 0000 0 0 001 0000 1000 0024 0024 0100 0000 0000 0000 0000 1000001 1024 1024 0024 0024

//--- verification/execute_stage_props.sv
/* Execute stage properties
   Reset, valid, stall hold and register jump checks on the EX/MEM register */

`timescale 1ns/10ps
`default_nettype none

module execute_stage_props (
   input logic                 clk,
   input logic                 rst,
   input logic                 stall,
   input logic                 in_valid,
   input logic                 jmp_reg_instr,
   input logic                 out_valid,
   input exec_data_pkg::word_t alu_out,
   input logic                 ofl,
   input logic                 zero,
   input logic                 ltz,
   input logic                 lteq,
   input logic                 set,
   input logic                 take_new_pc,
   input exec_data_pkg::word_t new_pc,
   input exec_data_pkg::word_t lbi,
   input exec_data_pkg::word_t slbi
);

   // Valid only rises for an accepted instruction
   a_valid_quiet: assert property (@(posedge clk)
      (rst || (!out_valid && !(in_valid && !stall))) |=> !out_valid)
      else $error("out_valid set without an accepted instruction");

   a_stall_hold: assert property (@(posedge clk) disable iff (rst)
      stall |=> $stable({out_valid, alu_out, ofl, zero, ltz, lteq, set,
                         take_new_pc, new_pc, lbi, slbi}))
      else $error("outputs changed during a stall");

   a_jr_target: assert property (@(posedge clk) disable iff (rst)
      (!stall && jmp_reg_instr) |=> (take_new_pc && new_pc == alu_out))
      else $error("register jump target differs from the ALU result");

   a_no_x: assert property (@(posedge clk) disable iff (rst)
      !$isunknown({out_valid, alu_out, ofl, zero, ltz, lteq, set,
                   take_new_pc, new_pc, lbi, slbi}))
      else $error("unknown value on a stage output");

endmodule

`default_nettype wire

//--- verification/tb_execute_stage.sv
/* Execute stage testbench
   Replays the vector file through the stage and checks the registered results */

`timescale 1ns/10ps
`default_nettype none

module tb_execute_stage;

   import exec_data_pkg::*;
   import exec_ctrl_pkg::*;

   localparam int MAX_LINES    = 200;
   localparam int DRAIN_CYCLES = 10;

   logic     clk;
   logic     rst;
   logic     stall;
   logic     in_valid;
   word_t    oprnd_1;
   word_t    oprnd_2;
   word_t    sext_imm;
   word_t    pc_inc;
   alu_op_t  alu_op;
   logic     alu_inv_a;
   logic     alu_inv_b;
   logic     alu_cin;
   logic     alu_sign;
   set_sel_t set_sel;
   br_cond_t br_cond;
   logic     br_instr;
   logic     jmp_instr;
   logic     jmp_reg_instr;
   logic     ex_fwd_rs;
   logic     ex_fwd_rt;
   logic     mem_fwd_rs;
   logic     mem_fwd_rt;
   word_t    ex_rs_val;
   word_t    ex_rt_val;
   word_t    mem_rs_val;
   word_t    mem_rt_val;

   logic     out_valid;
   word_t    alu_out;
   logic     ofl;
   logic     zero;
   logic     ltz;
   logic     lteq;
   logic     set;
   logic     take_new_pc;
   word_t    new_pc;
   word_t    lbi;
   word_t    slbi;

   // Fields of one vector line
   logic [3:0] alu_bits;
   logic [2:0] jump_bits;
   logic [3:0] fwd_bits;
   logic [6:0] v_flags;
   word_t      v_alu;
   word_t      v_pc;
   word_t      v_lbi;
   word_t      v_slbi;

   // Registered results of the last accepted instruction
   logic [6:0] exp_flags;
   word_t      exp_alu;
   word_t      exp_pc;
   word_t      exp_lbi;
   word_t      exp_slbi;

   execute_stage i_execute_stage (.*);

   bind execute_stage execute_stage_props i_execute_stage_props (
      .clk           (clk),
      .rst           (rst),
      .stall         (stall),
      .in_valid      (in_valid),
      .jmp_reg_instr (jmp_reg_instr),
      .out_valid     (out_valid),
      .alu_out       (alu_out),
      .ofl           (ofl),
      .zero          (zero),
      .ltz           (ltz),
      .lteq          (lteq),
      .set           (set),
      .take_new_pc   (take_new_pc),
      .new_pc        (new_pc),
      .lbi           (lbi),
      .slbi          (slbi)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   task automatic stop_on_error(input string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "simulation stopped at first error");
   endtask

   task automatic check_value(input string name, input word_t got, input word_t exp);
      assert (got === exp) else
         stop_on_error($sformatf("mismatch time=%0t signal=%s got=%h expected=%h",
                                 $time, name, got, exp));
   endtask

   task automatic check_outputs();
      check_value("out_valid", out_valid, word_t'(exp_flags[6]));
      check_value("ofl", ofl, word_t'(exp_flags[5]));
      check_value("zero", zero, word_t'(exp_flags[4]));
      check_value("ltz", ltz, word_t'(exp_flags[3]));
      check_value("lteq", lteq, word_t'(exp_flags[2]));
      check_value("set", set, word_t'(exp_flags[1]));
      check_value("take_new_pc", take_new_pc, word_t'(exp_flags[0]));
      check_value("alu_out", alu_out, exp_alu);
      check_value("new_pc", new_pc, exp_pc);
      check_value("lbi", lbi, exp_lbi);
      check_value("slbi", slbi, exp_slbi);
   endtask

   initial begin
      int    fd;
      int    n;
      int    lines;
      int    applied;
      int    waited;
      string line;

      rst = 1'b1;
      {stall, in_valid, alu_op, alu_inv_a, alu_inv_b, alu_cin, alu_sign} = '0;
      {set_sel, br_cond, br_instr, jmp_instr, jmp_reg_instr} = '0;
      {ex_fwd_rs, ex_fwd_rt, mem_fwd_rs, mem_fwd_rt} = '0;
      {oprnd_1, oprnd_2, sext_imm, pc_inc} = '0;
      {ex_rs_val, ex_rt_val, mem_rs_val, mem_rt_val} = '0;
      {exp_flags, exp_alu, exp_pc, exp_lbi, exp_slbi} = '0;

      repeat (16) @(negedge clk);
      rst = 1'b0;
      check_outputs();

      fd = $fopen("verification/exec_vectors.txt", "r");
      if (fd == 0)
         stop_on_error("cannot open verification/exec_vectors.txt");
      lines   = 0;
      applied = 0;
      while (!$feof(fd)) begin
         if (lines >= MAX_LINES)
            stop_on_error("vector read loop ran past its line limit");
         n = $fgets(line, fd);
         lines++;
         if (n > 1 && line.getc(0) != "#") begin
            n = $sscanf(line, "%h %h %h %b %h %h %b %b %h %h %h %h %h %h %h %h %b %h %h %h %h",
                        stall, in_valid, alu_op, alu_bits, set_sel, br_cond, jump_bits,
                        fwd_bits, oprnd_1, oprnd_2, sext_imm, pc_inc, ex_rs_val, ex_rt_val,
                        mem_rs_val, mem_rt_val, v_flags, v_alu, v_pc, v_lbi, v_slbi);
            if (n != 21)
               stop_on_error($sformatf("malformed vector on line %0d", lines));
            {alu_inv_a, alu_inv_b, alu_cin, alu_sign} = alu_bits;
            {br_instr, jmp_instr, jmp_reg_instr} = jump_bits;
            {ex_fwd_rs, ex_fwd_rt, mem_fwd_rs, mem_fwd_rt} = fwd_bits;
            @(negedge clk);
            // A stalled line leaves the register as it was
            if (!stall) begin
               exp_flags = v_flags;
               exp_alu   = v_alu;
               exp_pc    = v_pc;
               exp_lbi   = v_lbi;
               exp_slbi  = v_slbi;
            end
            check_outputs();
            applied++;
         end
      end
      $fclose(fd);

      // Drain with the last jump still on the control inputs
      in_valid = 1'b0;
      stall    = 1'b0;
      waited   = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (out_valid !== 1'b0 && waited < DRAIN_CYCLES);
      if (out_valid !== 1'b0)
         stop_on_error("out_valid did not drop after the last vector");
      check_value("take_new_pc", take_new_pc, 16'd1);

      // One more valid register jump, 1000 below ~0024 unsigned sets the flag
      in_valid  = 1'b1;
      set_sel   = SET_LT;
      alu_inv_b = 1'b1;
      @(negedge clk);
      check_value("out_valid", out_valid, 16'd1);
      check_value("set", set, 16'd1);
      check_value("take_new_pc", take_new_pc, 16'd1);

      // Reset wins over a stall
      rst   = 1'b1;
      stall = 1'b1;
      @(negedge clk);
      check_value("out_valid", out_valid, '0);
      check_value("take_new_pc", take_new_pc, '0);
      check_value("set", set, '0);
      check_value("alu_out", alu_out, '0);
      rst   = 1'b0;
      stall = 1'b0;

      if (applied == 0) begin
         stop_on_error("vector file held no vectors");
      end else begin
         $display("Finished with no errors");
      end
      $finish;
   end

endmodule

`default_nettype wire
